// ==== verilog/isaPkg.sv ====
package isaPkg;

	localparam int WORD_W = 32;
	localparam int REG_W = 5;
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W = 6;
	localparam int SHAMT_W = 5;
	localparam int IMM_W = 16;

	localparam int REG_COUNT = 32;

	typedef logic [REG_W-1:0] regIdx_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [FUNCT_W-1:0] funct_t;

	// Major opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_LI = 6'b001001;
	localparam opcode_t OP_LW = 6'b100011;
	localparam opcode_t OP_SW = 6'b101011;
	localparam opcode_t OP_XORI = 6'b001110;

	// R-type function codes
	localparam funct_t FUNCT_ADD = 6'b100000;
	localparam funct_t FUNCT_SUB = 6'b100010;
	localparam funct_t FUNCT_SLT = 6'b101010;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
		logic [SHAMT_W-1:0] shamt;
		funct_t funct;
	} rType_t;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rs;
		regIdx_t rt;
		logic [IMM_W-1:0] imm;
	} iType_t;

	// Same word, two field layouts
	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_t;

endpackage

// ==== verilog/pipePkg.sv ====
package pipePkg;

	import isaPkg::*;

	localparam int DATA_DEPTH = 256;
	localparam int DATA_ADDR_W = 8;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_XOR,
		ALU_PASS_IMM
	} aluOp_t;

	// ID/EX register
	typedef struct packed {
		logic valid;
		aluOp_t aluOp;
		logic useImm;
		logic memRead;
		logic memWrite;
		logic writeEn;
		regIdx_t dest;
		regIdx_t srcA;
		regIdx_t srcB;
		word_t operandA;
		word_t operandB;
		word_t imm;
	} exCtl_t;

	// EX/MEM register
	typedef struct packed {
		logic valid;
		logic memRead;
		logic memWrite;
		logic writeEn;
		regIdx_t dest;
		word_t aluResult;
		word_t storeData;
	} memCtl_t;

	typedef struct packed {
		logic valid;
		regIdx_t dest;
		word_t data;
	} regWrite_t;

endpackage

// ==== verilog/decodeStage.sv ====
module decodeStage import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input instr_t instr,
	input regWrite_t wbPort,
	output exCtl_t exCtl
);

	logic inValid;
	instr_t inWord;
	word_t regFile [REG_COUNT];
	word_t rdA;
	word_t rdB;
	exCtl_t nextCtl;
	logic legal;

	always_ff @(posedge clk) begin
		inWord <= instr;
		if (!rstN) begin
			inValid <= 1'b0;
		end else begin
			inValid <= instrValid;
		end
	end

	// Register file, zero entry never written
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int k = 0; k < REG_COUNT; k++) begin
				regFile[k] <= '0;
			end
		end else if (wbPort.valid) begin
			regFile[wbPort.dest] <= wbPort.data;
		end
	end

	// Write-first read
	assign rdA = (wbPort.valid && wbPort.dest == inWord.r.rs) ? wbPort.data : regFile[inWord.r.rs];
	assign rdB = (wbPort.valid && wbPort.dest == inWord.r.rt) ? wbPort.data : regFile[inWord.r.rt];

	always_comb begin
		nextCtl = '0;
		legal = 1'b1;
		nextCtl.valid = inValid;
		nextCtl.srcA = inWord.r.rs;
		nextCtl.srcB = inWord.r.rt;
		nextCtl.operandA = rdA;
		nextCtl.operandB = rdB;
		nextCtl.imm = {{(WORD_W - IMM_W){inWord.i.imm[IMM_W-1]}}, inWord.i.imm};
		nextCtl.dest = inWord.i.rt;
		nextCtl.aluOp = ALU_ADD;
		case (inWord.r.opcode)
			OP_RTYPE: begin
				nextCtl.dest = inWord.r.rd;
				nextCtl.writeEn = 1'b1;
				case (inWord.r.funct)
					FUNCT_ADD: nextCtl.aluOp = ALU_ADD;
					FUNCT_SUB: nextCtl.aluOp = ALU_SUB;
					FUNCT_SLT: nextCtl.aluOp = ALU_SLT;
					default: legal = 1'b0;
				endcase
			end
			OP_XORI: begin
				nextCtl.aluOp = ALU_XOR;
				nextCtl.useImm = 1'b1;
				nextCtl.writeEn = 1'b1;
			end
			OP_LI: begin
				nextCtl.aluOp = ALU_PASS_IMM;
				nextCtl.useImm = 1'b1;
				nextCtl.writeEn = 1'b1;
			end
			OP_LW: begin
				nextCtl.useImm = 1'b1;
				nextCtl.memRead = 1'b1;
				nextCtl.writeEn = 1'b1;
			end
			OP_SW: begin
				nextCtl.useImm = 1'b1;
				nextCtl.memWrite = 1'b1;
			end
			default: legal = 1'b0;
		endcase
		// Nothing reaches r0, idle slots do nothing
		if (nextCtl.dest == '0) begin
			nextCtl.writeEn = 1'b0;
		end
		if (!inValid) begin
			nextCtl.writeEn = 1'b0;
			nextCtl.memRead = 1'b0;
			nextCtl.memWrite = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exCtl.valid <= 1'b0;
			exCtl.memRead <= 1'b0;
			exCtl.memWrite <= 1'b0;
			exCtl.writeEn <= 1'b0;
		end else begin
			exCtl <= nextCtl;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) inValid |-> legal)
		else $error("decodeStage: unsupported opcode or function code %h", inWord);

endmodule

// ==== verilog/executeStage.sv ====
module executeStage import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input exCtl_t exCtl,
	input regWrite_t memFwd,
	input regWrite_t wbPort,
	output memCtl_t memCtl
);

	word_t opA;
	word_t opB;
	word_t aluB;
	word_t aluResult;
	logic lessThan;

	// Youngest producer wins
	function automatic word_t pickOperand(
		input regIdx_t src,
		input word_t readVal,
		input regWrite_t fwdMem,
		input regWrite_t fwdWb
	);
		if (fwdMem.valid && fwdMem.dest == src) begin
			return fwdMem.data;
		end
		if (fwdWb.valid && fwdWb.dest == src) begin
			return fwdWb.data;
		end
		return readVal;
	endfunction

	assign opA = pickOperand(exCtl.srcA, exCtl.operandA, memFwd, wbPort);
	assign opB = pickOperand(exCtl.srcB, exCtl.operandB, memFwd, wbPort);
	assign aluB = exCtl.useImm ? exCtl.imm : opB;
	assign lessThan = $signed(opA) < $signed(aluB);

	always_comb begin
		case (exCtl.aluOp)
			ALU_ADD: aluResult = opA + aluB;
			ALU_SUB: aluResult = opA - aluB;
			ALU_SLT: aluResult = {{(WORD_W - 1){1'b0}}, lessThan};
			ALU_XOR: aluResult = opA ^ aluB;
			ALU_PASS_IMM: aluResult = exCtl.imm;
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		memCtl.dest <= exCtl.dest;
		memCtl.aluResult <= aluResult;
		// Store data takes the forwarded rt value
		memCtl.storeData <= opB;
		if (!rstN) begin
			memCtl.valid <= 1'b0;
			memCtl.memRead <= 1'b0;
			memCtl.memWrite <= 1'b0;
			memCtl.writeEn <= 1'b0;
		end else begin
			memCtl.valid <= exCtl.valid;
			memCtl.memRead <= exCtl.memRead;
			memCtl.memWrite <= exCtl.memWrite;
			memCtl.writeEn <= exCtl.writeEn;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		exCtl.valid |-> !(exCtl.memRead && exCtl.memWrite))
		else $error("executeStage: load and store flagged together");

endmodule

// ==== verilog/memWriteback.sv ====
module memWriteback import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input memCtl_t memCtl,
	output regWrite_t memFwd,
	output regWrite_t wbPort
);

	word_t dataMem [DATA_DEPTH];
	logic [DATA_ADDR_W-1:0] memAddr;

	assign memAddr = memCtl.aluResult[DATA_ADDR_W-1:0];

	// Load data is not ready yet, so only ALU results forward from here
	assign memFwd = '{
		valid: memCtl.valid && memCtl.writeEn && !memCtl.memRead,
		dest: memCtl.dest,
		data: memCtl.aluResult
	};

	always_ff @(posedge clk) begin
		if (memCtl.valid && memCtl.memWrite) begin
			dataMem[memAddr] <= memCtl.storeData;
		end
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		wbPort.dest <= memCtl.dest;
		wbPort.data <= memCtl.memRead ? dataMem[memAddr] : memCtl.aluResult;
		if (!rstN) begin
			wbPort.valid <= 1'b0;
		end else begin
			wbPort.valid <= memCtl.valid && memCtl.writeEn;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) wbPort.valid |-> wbPort.dest != '0)
		else $error("memWriteback: write to register zero reached writeback");

endmodule

// ==== verilog/cpuCore.sv ====
module cpuCore import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input instr_t instr,
	output logic wbValid,
	output regIdx_t wbReg,
	output word_t wbData
);

	exCtl_t exCtl;
	memCtl_t memCtl;
	regWrite_t memFwd;
	regWrite_t wbPort;

	decodeStage i_decode (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.wbPort(wbPort),
		.exCtl(exCtl)
	);

	executeStage i_execute (
		.clk(clk),
		.rstN(rstN),
		.exCtl(exCtl),
		.memFwd(memFwd),
		.wbPort(wbPort),
		.memCtl(memCtl)
	);

	memWriteback i_memWb (
		.clk(clk),
		.rstN(rstN),
		.memCtl(memCtl),
		.memFwd(memFwd),
		.wbPort(wbPort)
	);

	assign wbValid = wbPort.valid;
	assign wbReg = wbPort.dest;
	assign wbData = wbPort.data;

endmodule

// ==== bench/cpuChecker.sv ====
module cpuChecker import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input int cycle,
	input logic wbValid,
	input regIdx_t wbReg,
	input word_t wbData
);

	timeunit 1ns;
	timeprecision 1ps;

	regWrite_t wantQ [$];
	string nameQ [$];
	int dueQ [$];
	int pending = 0;
	int passCount = 0;
	int errorCount = 0;
	regWrite_t want;
	string name;
	int due;

	task automatic queueWrite(regWrite_t rec, string testName, int dueCycle);
		wantQ.push_back(rec);
		nameQ.push_back(testName);
		dueQ.push_back(dueCycle);
		pending++;
	endtask

	// Mid-cycle sample, the port only moves on the rising edge
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			if (pending == 0) begin
				$display("Unexpected write of %h to r%0d in cycle %0d", wbData, wbReg, cycle);
				errorCount++;
			end else begin
				want = wantQ.pop_front();
				name = nameQ.pop_front();
				due = dueQ.pop_front();
				pending--;
				if (wbReg !== want.dest || wbData !== want.data) begin
					$display("ERROR %s: expected r%0d = %h, actual r%0d = %h",
						name, want.dest, want.data, wbReg, wbData);
					errorCount++;
				end else if (cycle != due) begin
					$display("ERROR %s: expected write in cycle %0d, actual cycle %0d",
						name, due, cycle);
					errorCount++;
				end else begin
					$display("ok %s: r%0d = %h", name, wbReg, wbData);
					passCount++;
				end
			end
		end
	end

	task automatic finalReport();
		if (pending != 0) begin
			$display("%0d expected writes never reached the writeback port", pending);
			errorCount += pending;
		end
		$display("Checks passed: %0d, failed: %0d", passCount, errorCount);
	endtask

endmodule

// ==== bench/cpuBench.sv ====
module cpuBench import isaPkg::*, pipePkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;
	localparam int NUM_STEPS = 22;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_STEPS + 4 + 20;
	// Drive edge to the mid-cycle sample where wbValid is high
	localparam int WB_DELAY = 5;

	logic clk;
	logic rstN;
	logic instrValid;
	instr_t instr;
	logic wbValid;
	regIdx_t wbReg;
	word_t wbData;
	int cycle = 0;
	logic [31:0] rngState = 32'hcefd;
	string stepName [NUM_STEPS];
	instr_t stepWord [NUM_STEPS];
	logic stepValid [NUM_STEPS];
	word_t refReg [REG_COUNT];
	word_t refMem [DATA_DEPTH];

	cpuCore i_dut (.*);
	cpuChecker i_checker (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Xorshift step giving a 16-bit immediate
	function automatic logic [15:0] randImm();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x[15:0];
	endfunction

	function automatic instr_t rWord(funct_t funct, regIdx_t rd, regIdx_t rs, regIdx_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic instr_t iWord(opcode_t op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic setStep(int k, string name, logic valid, instr_t word);
		stepName[k] = name;
		stepValid[k] = valid;
		stepWord[k] = word;
	endtask

	task automatic buildTable();
		logic [15:0] offset;
		offset = randImm();
		setStep(0, "li_pos", 1'b1, iWord(OP_LI, 1, 0, randImm()));
		setStep(1, "li_neg", 1'b1, iWord(OP_LI, 2, 0, randImm() | 16'h8000));
		setStep(2, "add_mem_fwd", 1'b1, rWord(FUNCT_ADD, 3, 1, 2));
		setStep(3, "sub_mem_fwd", 1'b1, rWord(FUNCT_SUB, 4, 1, 3));
		setStep(4, "slt_neg_lt", 1'b1, rWord(FUNCT_SLT, 5, 2, 4));
		setStep(5, "slt_neg_ge", 1'b1, rWord(FUNCT_SLT, 6, 4, 2));
		setStep(6, "li_xor_src", 1'b1, iWord(OP_LI, 8, 0, randImm()));
		setStep(7, "add_slt_sum", 1'b1, rWord(FUNCT_ADD, 9, 5, 6));
		setStep(8, "xori_wb_fwd", 1'b1, iWord(OP_XORI, 10, 8, randImm()));
		setStep(9, "xori_rf_bypass", 1'b1, iWord(OP_XORI, 11, 8, randImm()));
		setStep(10, "li_base", 1'b1, iWord(OP_LI, 12, 0, randImm()));
		setStep(11, "sw_store", 1'b1, iWord(OP_SW, 10, 12, offset));
		// Idle slot still carrying a real word
		setStep(12, "idle_after_sw", 1'b0, iWord(OP_LI, 13, 0, randImm()));
		setStep(13, "lw_load", 1'b1, iWord(OP_LW, 13, 12, offset));
		setStep(14, "add_to_r0", 1'b1, rWord(FUNCT_ADD, 0, 1, 2));
		setStep(15, "add_load_use", 1'b1, rWord(FUNCT_ADD, 14, 13, 0));
		setStep(16, "xori_to_r0", 1'b1, iWord(OP_XORI, 0, 1, randImm()));
		setStep(17, "idle_add", 1'b0, rWord(FUNCT_ADD, 15, 1, 1));
		setStep(18, "sub_from_r0", 1'b1, rWord(FUNCT_SUB, 15, 0, 1));
		setStep(19, "idle_sub", 1'b0, rWord(FUNCT_SUB, 17, 14, 1));
		setStep(20, "li_reload", 1'b1, iWord(OP_LI, 1, 0, randImm()));
		setStep(21, "add_in_order", 1'b1, rWord(FUNCT_ADD, 16, 1, 14));
	endtask

	// Architectural effect of one accepted instruction
	task automatic modelStep(int k, int due);
		instr_t w;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		regIdx_t dest;
		regWrite_t rec;
		w = stepWord[k];
		a = refReg[w.r.rs];
		b = refReg[w.r.rt];
		imm = {{16{w.i.imm[15]}}, w.i.imm};
		dest = (w.r.opcode == OP_RTYPE) ? w.r.rd : w.i.rt;
		case (w.r.opcode)
			OP_RTYPE: begin
				case (w.r.funct)
					FUNCT_ADD: res = a + b;
					FUNCT_SUB: res = a - b;
					default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				endcase
			end
			OP_XORI: res = a ^ imm;
			OP_LW: res = refMem[(a + imm) % DATA_DEPTH];
			OP_SW: begin
				refMem[(a + imm) % DATA_DEPTH] = b;
				// A store writes no register
				dest = '0;
			end
			default: res = imm;
		endcase
		if (dest != '0) begin
			refReg[dest] = res;
			rec = '{valid: 1'b1, dest: dest, data: res};
			i_checker.queueWrite(rec, stepName[k], due);
		end
	endtask

	initial begin
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		for (int r = 0; r < REG_COUNT; r++) begin
			refReg[r] = '0;
		end
		buildTable();
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		for (int k = 0; k < NUM_STEPS; k++) begin
			@(posedge clk);
			instrValid <= stepValid[k];
			instr <= stepWord[k];
			if (stepValid[k]) begin
				modelStep(k, cycle + WB_DELAY);
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		wait (i_checker.pending == 0);
		// Pipeline drain so a late stray pulse is still seen
		repeat (5) @(posedge clk);
		i_checker.finalReport();
		if (i_checker.errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles with %0d writes still outstanding",
			cycle, i_checker.pending);
		i_checker.finalReport();
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/cpuCore.sv
bench/cpuChecker.sv
bench/cpuBench.sv
